// ==== common/cpu_bus_pkg.sv ====
// CPU memory bus shared definitions

package cpu_bus_pkg;

    // --------------------------------------------------
    // widths and positions
    // --------------------------------------------------
    localparam int addr_w      = 32;  // byte address
    localparam int avm_addr_w  = 30;  // avalon word address
    localparam int data_w      = 32;
    localparam int a20_word_bit = 18; // byte address bit 20 seen as a word address bit

    localparam int fault_cnt_w = 8;
    localparam int apb_addr_w  = 4;

    // APB register offsets
    localparam logic [apb_addr_w-1:0] reg_ctrl_addr      = 4'h0;
    localparam logic [apb_addr_w-1:0] reg_fault_cnt_addr = 4'h4;

    // --------------------------------------------------
    // enums
    // --------------------------------------------------
    typedef enum logic {
        op_read,
        op_write
    } mem_op_e;

    typedef enum logic [1:0] {
        ms_idle,   // ready for a new request
        ms_cmd,    // command on the bus
        ms_rdata,  // waiting for readdatavalid
        ms_done    // response pulse
    } master_state_e;

    // --------------------------------------------------
    // structs
    // --------------------------------------------------
    typedef struct packed {
        mem_op_e             op;
        logic [addr_w-1:0]   address;
        logic [2:0]          length;  // 1 to 4 bytes
        logic [data_w-1:0]   data;
    } mem_req_t;

    typedef struct packed {
        logic                done;
        logic [data_w-1:0]   data;    // aligned to byte 0
    } mem_rsp_t;

    typedef struct packed {
        logic a20_enable;
        logic align_check;
    } mem_cfg_t;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [apb_addr_w-1:0] paddr;
        logic [data_w-1:0]     pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [data_w-1:0] prdata;
        logic              pslverr;
    } apb_rsp_t;

endpackage

// ==== logic/bus_ctrl_regs.sv ====
// Bus control register block
`timescale 1ns/1ps

module bus_ctrl_regs (
    input  logic                  clk,
    input  logic                  rst_n,

    input  cpu_bus_pkg::apb_req_t apb_req,
    output cpu_bus_pkg::apb_rsp_t apb_rsp,

    input  logic                  ac_fault,  // one pulse per alignment fault
    output cpu_bus_pkg::mem_cfg_t cfg
);

// --------------------------------------------------
// access decode
// --------------------------------------------------
logic access;
logic wr_en;
logic hit_ctrl;
logic hit_fault_cnt;

logic [cpu_bus_pkg::fault_cnt_w-1:0] fault_cnt;

assign access        = apb_req.psel & apb_req.penable;  // access phase
assign wr_en         = access & apb_req.pwrite;
assign hit_ctrl      = (apb_req.paddr == cpu_bus_pkg::reg_ctrl_addr);
assign hit_fault_cnt = (apb_req.paddr == cpu_bus_pkg::reg_fault_cnt_addr);

// --------------------------------------------------
// CTRL register
// --------------------------------------------------
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        cfg <= '0;
    end else if (wr_en && hit_ctrl) begin
        cfg.a20_enable  <= apb_req.pwdata[0];
        cfg.align_check <= apb_req.pwdata[1];
    end
end

// FAULT_CNT saturates, any write clears it
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        fault_cnt <= '0;
    end else if (wr_en && hit_fault_cnt) begin
        fault_cnt <= '0;
    end else if (ac_fault && !(&fault_cnt)) begin
        fault_cnt <= fault_cnt + 1'b1;
    end
end

// --------------------------------------------------
// read data and error
// --------------------------------------------------
always_comb begin
    apb_rsp.prdata  = '0;
    apb_rsp.pslverr = 1'b0;
    if (hit_ctrl) begin
        apb_rsp.prdata[1:0] = {cfg.align_check, cfg.a20_enable};
    end else if (hit_fault_cnt) begin
        apb_rsp.prdata[cpu_bus_pkg::fault_cnt_w-1:0] = fault_cnt;
    end else begin
        apb_rsp.pslverr = access;  // unknown offset
    end
end

endmodule

// ==== logic/cpu_mem_top.sv ====
// CPU memory bus top level
`timescale 1ns/1ps

module cpu_mem_top (
    input  logic                                clk,
    input  logic                                rst_n,

    // configuration port
    input  cpu_bus_pkg::apb_req_t               apb_req,
    output cpu_bus_pkg::apb_rsp_t               apb_rsp,

    // --------------------------------------------------
    // requester
    // --------------------------------------------------
    input  logic                                read_do,
    input  logic [cpu_bus_pkg::addr_w-1:0]      read_address,
    input  logic [2:0]                          read_length,
    output logic                                read_done,
    output logic                                read_ac_fault,
    output logic [cpu_bus_pkg::data_w-1:0]      read_data,

    input  logic                                write_do,
    input  logic [cpu_bus_pkg::addr_w-1:0]      write_address,
    input  logic [2:0]                          write_length,
    input  logic [cpu_bus_pkg::data_w-1:0]      write_data,
    output logic                                write_done,
    output logic                                write_ac_fault,

    // --------------------------------------------------
    // memory bus
    // --------------------------------------------------
    output logic [cpu_bus_pkg::avm_addr_w-1:0]  avm_address,
    output logic [cpu_bus_pkg::data_w-1:0]      avm_writedata,
    output logic [3:0]                          avm_byteenable,
    output logic                                avm_read,
    output logic                                avm_write,
    input  logic                                avm_waitrequest,
    input  logic                                avm_readdatavalid,
    input  logic [cpu_bus_pkg::data_w-1:0]      avm_readdata
);

cpu_bus_pkg::mem_cfg_t cfg;
cpu_bus_pkg::mem_req_t req;
cpu_bus_pkg::mem_rsp_t rsp;
logic                  req_valid;
logic                  req_ready;
logic                  ac_fault;

bus_ctrl_regs i_bus_ctrl_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .ac_fault  (ac_fault),   // fault pulse from arbiter
    .cfg       (cfg)
);

mem_req_arbiter i_mem_req_arbiter (
    .clk            (clk),
    .rst_n          (rst_n),
    .read_do        (read_do),
    .read_address   (read_address),
    .read_length    (read_length),
    .read_done      (read_done),
    .read_ac_fault  (read_ac_fault),
    .read_data      (read_data),
    .write_do       (write_do),
    .write_address  (write_address),
    .write_length   (write_length),
    .write_data     (write_data),
    .write_done     (write_done),
    .write_ac_fault (write_ac_fault),
    .cfg            (cfg),
    .req            (req),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .rsp            (rsp),
    .ac_fault       (ac_fault)
);

avalon_master i_avalon_master (
    .clk               (clk),
    .rst_n             (rst_n),
    .cfg               (cfg),
    .req               (req),
    .req_valid         (req_valid),
    .req_ready         (req_ready),
    .rsp               (rsp),
    .avm_address       (avm_address),
    .avm_writedata     (avm_writedata),
    .avm_byteenable    (avm_byteenable),
    .avm_read          (avm_read),
    .avm_write         (avm_write),
    .avm_waitrequest   (avm_waitrequest),
    .avm_readdatavalid (avm_readdatavalid),
    .avm_readdata      (avm_readdata)
);

endmodule

// ==== memory/avalon_master.sv ====
// Avalon-MM bus master
`timescale 1ns/1ps

module avalon_master (
    input  logic                                clk,
    input  logic                                rst_n,

    input  cpu_bus_pkg::mem_cfg_t               cfg,

    input  cpu_bus_pkg::mem_req_t               req,
    input  logic                                req_valid,
    output logic                                req_ready,
    output cpu_bus_pkg::mem_rsp_t               rsp,

    // avalon
    output logic [cpu_bus_pkg::avm_addr_w-1:0]  avm_address,
    output logic [cpu_bus_pkg::data_w-1:0]      avm_writedata,
    output logic [3:0]                          avm_byteenable,
    output logic                                avm_read,
    output logic                                avm_write,
    input  logic                                avm_waitrequest,
    input  logic                                avm_readdatavalid,
    input  logic [cpu_bus_pkg::data_w-1:0]      avm_readdata
);

// --------------------------------------------------
// request registers
// --------------------------------------------------
cpu_bus_pkg::master_state_e state;
cpu_bus_pkg::mem_req_t      cur;      // request in progress
logic                       phase;    // 0 first word, 1 second word
logic                       a20_gate; // a20_enable taken at accept

logic [2*cpu_bus_pkg::data_w-1:0] rd_buf;    // both read words
logic [2*cpu_bus_pkg::data_w-1:0] wide_wdata;
logic [2*cpu_bus_pkg::data_w-1:0] rd_shift;
logic [7:0]                       lane_mask; // bytes over two words
logic [1:0]                       off;
logic                             crossing;
logic                             accept;
logic [cpu_bus_pkg::avm_addr_w-1:0] cmd_word;

assign req_ready = (state == cpu_bus_pkg::ms_idle);
assign accept    = req_valid && req_ready;

// --------------------------------------------------
// word split and byte lanes
// --------------------------------------------------
assign off        = cur.address[1:0];
assign crossing   = (4'(off) + 4'(cur.length)) > 4'd4;
assign lane_mask  = ((8'd1 << cur.length) - 8'd1) << off;
assign wide_wdata = {{cpu_bus_pkg::data_w{1'b0}}, cur.data} << {off, 3'b000};

assign cmd_word = cur.address[cpu_bus_pkg::addr_w-1:2] + cpu_bus_pkg::avm_addr_w'(phase);

always_comb begin
    avm_address = cmd_word;
    if (!a20_gate) avm_address[cpu_bus_pkg::a20_word_bit] = 1'b0;  // A20 masked
end

assign avm_byteenable = phase ? lane_mask[7:4] : lane_mask[3:0];
assign avm_writedata  = phase ? wide_wdata[2*cpu_bus_pkg::data_w-1:cpu_bus_pkg::data_w]
                              : wide_wdata[cpu_bus_pkg::data_w-1:0];

assign avm_read  = (state == cpu_bus_pkg::ms_cmd) && (cur.op == cpu_bus_pkg::op_read);
assign avm_write = (state == cpu_bus_pkg::ms_cmd) && (cur.op == cpu_bus_pkg::op_write);

// --------------------------------------------------
// transfer FSM
// --------------------------------------------------
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state    <= cpu_bus_pkg::ms_idle;
        phase    <= 1'b0;
        a20_gate <= 1'b0;
    end else begin
        case (state)
            cpu_bus_pkg::ms_idle: begin
                if (accept) begin
                    state    <= cpu_bus_pkg::ms_cmd;
                    phase    <= 1'b0;
                    a20_gate <= cfg.a20_enable;
                end
            end
            cpu_bus_pkg::ms_cmd: begin
                if (!avm_waitrequest) begin
                    if (cur.op == cpu_bus_pkg::op_read) begin
                        state <= cpu_bus_pkg::ms_rdata;  // one outstanding read
                    end else if (!phase && crossing) begin
                        phase <= 1'b1;
                    end else begin
                        state <= cpu_bus_pkg::ms_done;
                    end
                end
            end
            cpu_bus_pkg::ms_rdata: begin
                if (avm_readdatavalid) begin
                    if (!phase && crossing) begin
                        phase <= 1'b1;
                        state <= cpu_bus_pkg::ms_cmd;
                    end else begin
                        state <= cpu_bus_pkg::ms_done;
                    end
                end
            end
            default: begin  // ms_done
                state <= cpu_bus_pkg::ms_idle;
            end
        endcase
    end
end

// payload capture
always_ff @(posedge clk) begin
    if (accept) cur <= req;
    if (state == cpu_bus_pkg::ms_rdata && avm_readdatavalid) begin
        if (phase) rd_buf[2*cpu_bus_pkg::data_w-1:cpu_bus_pkg::data_w] <= avm_readdata;
        else       rd_buf[cpu_bus_pkg::data_w-1:0] <= avm_readdata;
    end
end

// --------------------------------------------------
// response
// --------------------------------------------------
assign rd_shift = rd_buf >> {off, 3'b000};

always_comb begin
    rsp.done = (state == cpu_bus_pkg::ms_done);
    rsp.data = '0;
    for (int i = 0; i < 4; i++) begin
        if (i < cur.length) rsp.data[8*i +: 8] = rd_shift[8*i +: 8];  // bytes above length stay 0
    end
end

endmodule

// ==== memory/mem_req_arbiter.sv ====
// Memory request arbiter
`timescale 1ns/1ps

module mem_req_arbiter (
    input  logic                                 clk,
    input  logic                                 rst_n,

    // read port
    input  logic                                 read_do,
    input  logic [cpu_bus_pkg::addr_w-1:0]       read_address,
    input  logic [2:0]                           read_length,
    output logic                                 read_done,
    output logic                                 read_ac_fault,
    output logic [cpu_bus_pkg::data_w-1:0]       read_data,

    // write port
    input  logic                                 write_do,
    input  logic [cpu_bus_pkg::addr_w-1:0]       write_address,
    input  logic [2:0]                           write_length,
    input  logic [cpu_bus_pkg::data_w-1:0]       write_data,
    output logic                                 write_done,
    output logic                                 write_ac_fault,

    input  cpu_bus_pkg::mem_cfg_t                cfg,

    // to the bus master
    output cpu_bus_pkg::mem_req_t                req,
    output logic                                 req_valid,
    input  logic                                 req_ready,
    input  cpu_bus_pkg::mem_rsp_t                rsp,

    output logic                                 ac_fault
);

// --------------------------------------------------
// grant and alignment check
// --------------------------------------------------
logic                   busy;           // a request is owned
logic                   fault_pending;  // misaligned, answer locally
logic                   grant;
logic                   next_fault;
cpu_bus_pkg::mem_op_e   owner;
cpu_bus_pkg::mem_req_t  next_req;

// no grant while a done pulse is out, the requester still holds do
assign grant = !busy && !read_done && !write_done && (read_do || write_do);

always_comb begin
    if (write_do) begin  // write wins
        next_req.op      = cpu_bus_pkg::op_write;
        next_req.address = write_address;
        next_req.length  = write_length;
        next_req.data    = write_data;
    end else begin
        next_req.op      = cpu_bus_pkg::op_read;
        next_req.address = read_address;
        next_req.length  = read_length;
        next_req.data    = '0;
    end
end

assign next_fault = cfg.align_check &&
                    ((next_req.length == 3'd2 && next_req.address[0]) ||
                     (next_req.length == 3'd4 && next_req.address[1:0] != 2'b00));

// --------------------------------------------------
// control
// --------------------------------------------------
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        busy           <= 1'b0;
        owner          <= cpu_bus_pkg::op_read;
        fault_pending  <= 1'b0;
        req_valid      <= 1'b0;
        read_done      <= 1'b0;
        write_done     <= 1'b0;
        read_ac_fault  <= 1'b0;
        write_ac_fault <= 1'b0;
    end else begin
        read_done      <= 1'b0;  // pulses
        write_done     <= 1'b0;
        read_ac_fault  <= 1'b0;
        write_ac_fault <= 1'b0;

        if (grant) begin
            busy  <= 1'b1;
            owner <= next_req.op;
            if (next_fault) fault_pending <= 1'b1;
            else            req_valid     <= 1'b1;
        end

        if (req_valid && req_ready) req_valid <= 1'b0;

        // fault or master response ends the request
        if (fault_pending || rsp.done) begin
            busy          <= 1'b0;
            fault_pending <= 1'b0;
            if (owner == cpu_bus_pkg::op_write) begin
                write_done     <= 1'b1;
                write_ac_fault <= fault_pending;
            end else begin
                read_done     <= 1'b1;
                read_ac_fault <= fault_pending;
            end
        end
    end
end

// payload
always_ff @(posedge clk) begin
    if (grant) req <= next_req;
    if (rsp.done && owner == cpu_bus_pkg::op_read) read_data <= rsp.data;
end

assign ac_fault = read_ac_fault | write_ac_fault;  // to fault counter

endmodule

// ==== sim.f ====
common/cpu_bus_pkg.sv
logic/bus_ctrl_regs.sv
memory/mem_req_arbiter.sv
memory/avalon_master.sv
logic/cpu_mem_top.sv
tests/tb_clock_gen.sv
tests/cpu_mem_asserts.sv
tests/tb_cpu_mem.sv

// ==== tests/cpu_mem_asserts.sv ====
// Memory bus checker
`timescale 1ns/1ps

module cpu_mem_asserts (
    input logic                               clk,
    input logic                               rst_n,
    input cpu_bus_pkg::apb_req_t              apb_req,
    input cpu_bus_pkg::apb_rsp_t              apb_rsp,
    input logic                               read_do,
    input logic [cpu_bus_pkg::addr_w-1:0]     read_address,
    input logic [2:0]                         read_length,
    input logic                               read_done,
    input logic                               read_ac_fault,
    input logic [cpu_bus_pkg::data_w-1:0]     read_data,
    input logic                               write_do,
    input logic [cpu_bus_pkg::addr_w-1:0]     write_address,
    input logic [2:0]                         write_length,
    input logic [cpu_bus_pkg::data_w-1:0]     write_data,
    input logic                               write_done,
    input logic                               write_ac_fault,
    input logic [cpu_bus_pkg::avm_addr_w-1:0] avm_address,
    input logic [cpu_bus_pkg::data_w-1:0]     avm_writedata,
    input logic [3:0]                         avm_byteenable,
    input logic                               avm_read,
    input logic                               avm_write,
    input logic                               avm_waitrequest
);

int fail_count = 0;

logic [1:0]                          ctrl_q;   // expected CTRL contents
logic [cpu_bus_pkg::fault_cnt_w-1:0] fault_q;  // expected FAULT_CNT
int                                  rd_cnt;   // accepted reads of this request
int                                  wr_cnt;
logic                                apb_acc;

assign apb_acc = apb_req.psel && apb_req.penable;

task automatic count_failure(input string what);
    fail_count++;
    $error("** Error %0t: %s", $time, what);
endtask

// --------------------------------------------------
// expected values
// --------------------------------------------------
function automatic logic misaligned(input logic chk, input logic [31:0] addr,
                                    input logic [2:0] len);
    return chk && ((len == 3'd2 && addr[0]) || (len == 3'd4 && addr[1:0] != 2'b00));
endfunction

function automatic int word_count(input logic [31:0] addr, input logic [2:0] len);
    return (int'(addr[1:0]) + int'(len) > 4) ? 2 : 1;
endfunction

function automatic logic [29:0] exp_word(input logic [31:0] addr, input int k,
                                         input logic a20);
    logic [29:0] w;
    w = addr[31:2] + 30'(k);
    if (!a20) w[cpu_bus_pkg::a20_word_bit] = 1'b0;
    return w;
endfunction

function automatic logic [31:0] exp_rdata(input logic [31:0] addr, input logic [2:0] len);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < 4; i++) begin
        if (i < int'(len)) v[8*i +: 8] = 8'(addr + 32'(i)) ^ 8'h5a;
    end
    return v;
endfunction

function automatic logic lanes_ok(input logic [31:0] addr, input logic [2:0] len,
                                  input logic [31:0] data, input int k,
                                  input logic [3:0] be, input logic [31:0] wd);
    int   i;
    logic ok;
    ok = 1'b1;
    for (int j = 0; j < 4; j++) begin
        i = 4 * k + j - int'(addr[1:0]);  // byte index within the request
        if (i >= 0 && i < int'(len)) ok = ok && be[j] && (wd[8*j +: 8] == data[8*i +: 8]);
        else                         ok = ok && !be[j];
    end
    return ok;
endfunction

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        ctrl_q  <= '0;
        fault_q <= '0;
        rd_cnt  <= 0;
        wr_cnt  <= 0;
    end else begin
        if (apb_acc && apb_req.pwrite && apb_req.paddr == cpu_bus_pkg::reg_ctrl_addr)
            ctrl_q <= apb_req.pwdata[1:0];
        if (apb_acc && apb_req.pwrite && apb_req.paddr == cpu_bus_pkg::reg_fault_cnt_addr)
            fault_q <= '0;
        else if (((read_done && misaligned(ctrl_q[1], read_address, read_length)) ||
                  (write_done && misaligned(ctrl_q[1], write_address, write_length))) &&
                 !(&fault_q))
            fault_q <= fault_q + 1'b1;
        if (read_done)                         rd_cnt <= 0;
        else if (avm_read && !avm_waitrequest) rd_cnt <= rd_cnt + 1;
        if (write_done)                         wr_cnt <= 0;
        else if (avm_write && !avm_waitrequest) wr_cnt <= wr_cnt + 1;
    end
end

// --------------------------------------------------
// requester side
// --------------------------------------------------
a_read_end: assert property (@(posedge clk) disable iff (!rst_n)
    read_done |-> read_ac_fault == misaligned(ctrl_q[1], read_address, read_length) &&
        rd_cnt == (read_ac_fault ? 0 : word_count(read_address, read_length)))
    else count_failure("read fault flag or word count");

a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
    read_done && !misaligned(ctrl_q[1], read_address, read_length) |->
        read_data == exp_rdata(read_address, read_length))
    else count_failure("read data");

a_write_end: assert property (@(posedge clk) disable iff (!rst_n)
    write_done |-> write_ac_fault == misaligned(ctrl_q[1], write_address, write_length) &&
        wr_cnt == (write_ac_fault ? 0 : word_count(write_address, write_length)))
    else count_failure("write fault flag or write count");

a_read_fault_time: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(read_do) && misaligned(ctrl_q[1], read_address, read_length) |->
        (!avm_read && !avm_write)[*2] ##1 (read_done && read_ac_fault && !avm_read))
    else count_failure("misaligned read timing");

a_write_fault_time: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(write_do) && misaligned(ctrl_q[1], write_address, write_length) |->
        (!avm_read && !avm_write)[*2] ##1 (write_done && write_ac_fault && !avm_write))
    else count_failure("misaligned write timing");

// --------------------------------------------------
// Avalon side
// --------------------------------------------------
a_write_lanes: assert property (@(posedge clk) disable iff (!rst_n)
    avm_write && !avm_waitrequest |-> lanes_ok(write_address, write_length, write_data,
                                               wr_cnt, avm_byteenable, avm_writedata))
    else count_failure("write byteenable or lane data");

a_cmd_address: assert property (@(posedge clk) disable iff (!rst_n)
    avm_read || avm_write |-> avm_address == (avm_write ?
        exp_word(write_address, wr_cnt, ctrl_q[0]) : exp_word(read_address, rd_cnt, ctrl_q[0])))
    else count_failure("command word address");

a_a20_masked: assert property (@(posedge clk) disable iff (!rst_n)
    (avm_read || avm_write) && !ctrl_q[0] |-> !avm_address[cpu_bus_pkg::a20_word_bit])
    else count_failure("address bit 18 with A20 masked");

a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (avm_read || avm_write) && avm_waitrequest |=>
        $stable({avm_read, avm_write, avm_address, avm_writedata, avm_byteenable}))
    else count_failure("command changed under waitrequest");

a_cmd_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    !(avm_read && avm_write))
    else count_failure("read and write together");

// --------------------------------------------------
// APB side
// --------------------------------------------------
a_apb_err: assert property (@(posedge clk) disable iff (!rst_n)
    apb_acc |-> apb_rsp.pslverr == (apb_req.paddr != cpu_bus_pkg::reg_ctrl_addr &&
                                    apb_req.paddr != cpu_bus_pkg::reg_fault_cnt_addr))
    else count_failure("pslverr");

a_ctrl_read: assert property (@(posedge clk) disable iff (!rst_n)
    apb_acc && !apb_req.pwrite && apb_req.paddr == cpu_bus_pkg::reg_ctrl_addr |->
        apb_rsp.prdata == {30'b0, ctrl_q})
    else count_failure("CTRL read value");

a_fault_cnt_read: assert property (@(posedge clk) disable iff (!rst_n)
    apb_acc && !apb_req.pwrite && apb_req.paddr == cpu_bus_pkg::reg_fault_cnt_addr |->
        apb_rsp.prdata == 32'(fault_q))
    else count_failure("FAULT_CNT read value");

endmodule

bind cpu_mem_top cpu_mem_asserts i_cpu_mem_asserts (.*);

// ==== tests/tb_clock_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
end

initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
end

endmodule

// ==== tests/tb_cpu_mem.sv ====
// CPU memory bus testbench
`timescale 1ns/1ps

module tb_cpu_mem;

localparam int n_transfers     = 40;
localparam int cycles_per_xfer = 24;
localparam int timeout_cycles  = n_transfers * cycles_per_xfer + 100;

logic                   clk;
logic                   rst_n;
cpu_bus_pkg::apb_req_t  apb_req;
cpu_bus_pkg::apb_rsp_t  apb_rsp;
logic                   read_do;
logic [31:0]            read_address;
logic [2:0]             read_length;
logic                   read_done;
logic                   read_ac_fault;
logic [31:0]            read_data;
logic                   write_do;
logic [31:0]            write_address;
logic [2:0]             write_length;
logic [31:0]            write_data;
logic                   write_done;
logic                   write_ac_fault;
logic [29:0]            avm_address;
logic [31:0]            avm_writedata;
logic [3:0]             avm_byteenable;
logic                   avm_read;
logic                   avm_write;
logic                   avm_waitrequest;
logic                   avm_readdatavalid;
logic [31:0]            avm_readdata;

logic [15:0] lfsr = 16'd64646;
int          cycles = 0;
int          timeouts = 0;

// slave model state
logic        in_cmd = 1'b0;
logic        cmd_read;
logic [29:0] cmd_word;
int          wait_left;
int          rdv_delay = 0;

tb_clock_gen i_tb_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
);

cpu_mem_top i_cpu_mem_top (.*);

function automatic logic next_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 16'hb400;  // galois taps 16,14,13,11
    return b;
endfunction

function automatic logic [31:0] next_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], next_bit()};
    return v;
endfunction

task automatic finish_run();
    int assert_fails;
    assert_fails = i_cpu_mem_top.i_cpu_mem_asserts.fail_count;
    $display("assertion failures: %0d, timeouts: %0d", assert_fails, timeouts);
    if (assert_fails == 0 && timeouts == 0) begin
        $display("No errors");
    end else begin
        $display("Errors found");
    end
    $finish;
endtask

always @(posedge clk) begin
    cycles++;
    if (cycles > timeout_cycles) begin
        $display("timeout: the run did not end within %0d cycles", timeout_cycles);
        timeouts = 1;
        finish_run();
    end
end

// --------------------------------------------------
// Avalon slave model
// --------------------------------------------------
always @(negedge clk) begin
    if (!rst_n) begin
        avm_waitrequest   = 1'b0;
        avm_readdatavalid = 1'b0;
        in_cmd            = 1'b0;
        rdv_delay         = 0;
    end else begin
        avm_readdatavalid = 1'b0;
        if (in_cmd) begin
            if (!avm_waitrequest) begin  // taken at the last rising edge
                in_cmd = 1'b0;
                if (cmd_read) rdv_delay = 1 + int'(next_bits(1));
            end else begin
                wait_left--;
                avm_waitrequest = (wait_left != 0);
            end
        end
        if (!in_cmd && (avm_read || avm_write)) begin
            in_cmd          = 1'b1;
            cmd_read        = avm_read;
            cmd_word        = avm_address;
            wait_left       = int'(next_bits(2));  // 0 to 3 wait cycles
            avm_waitrequest = (wait_left != 0);
        end
        if (rdv_delay != 0) begin
            rdv_delay--;
            if (rdv_delay == 0) begin
                avm_readdatavalid = 1'b1;
                for (int j = 0; j < 4; j++)
                    avm_readdata[8*j +: 8] = {cmd_word[5:0], 2'(j)} ^ 8'h5a;
            end
        end
    end
end

// --------------------------------------------------
// requester and APB tasks
// --------------------------------------------------
task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata);
    apb_req.psel    = 1'b1;  // setup
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;  // access
    @(negedge clk);
    apb_req = '0;
endtask

task automatic read_transfer(input logic [31:0] addr, input logic [2:0] len);
    read_address = addr;
    read_length  = len;
    read_do      = 1'b1;
    do @(negedge clk); while (!read_done);
    read_do = 1'b0;
    @(negedge clk);
endtask

task automatic write_transfer(input logic [31:0] addr, input logic [2:0] len,
                              input logic [31:0] data);
    write_address = addr;
    write_length  = len;
    write_data    = data;
    write_do      = 1'b1;
    do @(negedge clk); while (!write_done);
    write_do = 1'b0;
    @(negedge clk);
endtask

task automatic random_transfer(input logic set_a20, input logic misalign);
    logic [31:0] addr;
    logic [2:0]  len;
    logic [31:0] data;
    addr = next_bits(32);
    len  = 3'(next_bits(2)) + 3'd1;
    data = next_bits(32);
    if (set_a20) addr[20] = 1'b1;
    if (misalign) begin
        len     = next_bits(1) ? 3'd4 : 3'd2;
        addr[0] = 1'b1;
    end
    if (next_bits(1)) write_transfer(addr, len, data);
    else              read_transfer(addr, len);
endtask

initial begin
    apb_req           = '0;
    read_do           = 1'b0;
    read_address      = '0;
    read_length       = '0;
    write_do          = 1'b0;
    write_address     = '0;
    write_length      = '0;
    write_data        = '0;
    avm_waitrequest   = 1'b0;
    avm_readdatavalid = 1'b0;
    avm_readdata      = '0;
    wait (rst_n === 1'b1);
    @(negedge clk);

    apb_access(1'b1, cpu_bus_pkg::reg_ctrl_addr, 32'h0);
    apb_access(1'b0, cpu_bus_pkg::reg_ctrl_addr, 32'h0);
    apb_access(1'b0, 4'h8, 32'h0);  // unmapped offset
    apb_access(1'b1, 4'h8, 32'hffff_ffff);

    for (int n = 0; n < 14; n++) random_transfer(n[0], 1'b0);  // A20 masked

    apb_access(1'b1, cpu_bus_pkg::reg_ctrl_addr, 32'h1);
    for (int n = 0; n < 10; n++) random_transfer(1'b1, 1'b0);

    // alignment check with junk in upper CTRL bits
    apb_access(1'b1, cpu_bus_pkg::reg_ctrl_addr, 32'ha5a5_a5a7);
    apb_access(1'b0, cpu_bus_pkg::reg_ctrl_addr, 32'h0);
    apb_access(1'b1, cpu_bus_pkg::reg_fault_cnt_addr, 32'h0);
    for (int n = 0; n < 16; n++) random_transfer(next_bit(), n[0]);
    apb_access(1'b0, cpu_bus_pkg::reg_fault_cnt_addr, 32'h0);
    apb_access(1'b1, cpu_bus_pkg::reg_fault_cnt_addr, 32'h1);
    apb_access(1'b0, cpu_bus_pkg::reg_fault_cnt_addr, 32'h0);

    apb_access(1'b1, cpu_bus_pkg::reg_ctrl_addr, next_bits(32));
    apb_access(1'b0, cpu_bus_pkg::reg_ctrl_addr, 32'h0);
    repeat (4) @(negedge clk);
    finish_run();
end

endmodule
